// ==== hdl/boot_pkg.sv ====
// ----------------------------
// Shared sizes, timing constants and helpers for the boot copier
// Referenced by scoped name from the RTL and the testbench
// ----------------------------
package boot_pkg;

  localparam int flash_addr_width = 22;                    // Flash byte address
  localparam int sram_addr_width  = 18;                    // SRAM word address
  localparam int word_width       = 16;                    // Copied word
  localparam int word_index_width = flash_addr_width - 1;  // Word address into flash

  localparam logic [sram_addr_width-1:0] block_words = 18'd16;  // Words per strap step

  // Flash read timing
  localparam int flash_wait      = 4;                      // Cycles to a valid byte
  localparam int flash_wait_bits = (flash_wait > 0) ? $clog2(flash_wait + 1) : 1;
  localparam logic [flash_wait_bits-1:0] flash_wait_last = flash_wait[flash_wait_bits-1:0];

  // SRAM write strobe timing
  localparam int write_low_cycles = 2;                     // Strobe low time
  localparam int write_cnt_bits   = (write_low_cycles > 1) ? $clog2(write_low_cycles) : 1;
  localparam logic [write_cnt_bits-1:0] write_cnt_last =
    write_cnt_bits'(write_low_cycles - 1);                 // Last low cycle

  typedef enum logic [2:0] {
    st_idle,                                               // Latch word total
    st_fetch,                                              // First read request
    st_wait_word,                                          // Waiting on flash reader
    st_store,                                              // Hand word to writer
    st_done                                                // Copy finished
  } copier_state_t;

  // Hex nibble to active low segments, bit 0 is segment a
  function automatic logic [6:0] seg_encode(input logic [3:0] nibble);
    logic [6:0] seg;
    case (nibble)
      4'h0:    seg = 7'b1000000;
      4'h1:    seg = 7'b1111001;
      4'h2:    seg = 7'b0100100;
      4'h3:    seg = 7'b0110000;
      4'h4:    seg = 7'b0011001;
      4'h5:    seg = 7'b0010010;
      4'h6:    seg = 7'b0000010;
      4'h7:    seg = 7'b1111000;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0010000;
      4'ha:    seg = 7'b0001000;
      4'hb:    seg = 7'b0000011;
      4'hc:    seg = 7'b1000110;
      4'hd:    seg = 7'b0100001;
      4'he:    seg = 7'b0000110;
      default: seg = 7'b0001110;                           // F
    endcase
    return seg;
  endfunction

endpackage

// ==== hdl/flash_reader.sv ====
// ----------------------------
// Flash read side of the copier
// Turns a fetch pulse into two timed byte reads and one 16-bit word
// ----------------------------
`timescale 1ns/1ps

module flash_reader (
  input  logic                                  clock_24,
  input  logic                                  reset,
  input  logic                                  fetch,       // Start word read
  input  logic [boot_pkg::word_index_width-1:0] word_index,  // Word to read
  output logic [boot_pkg::flash_addr_width-1:0] fl_addr,
  input  logic [7:0]                            fl_dq,
  output logic                                  fl_ce_n,
  output logic                                  fl_oe_n,
  output logic                                  fl_we_n,
  output logic                                  fl_rst_n,
  output logic [boot_pkg::word_width-1:0]       word_data,
  output logic                                  word_valid   // One cycle pulse
);

  logic                                 reading;     // Read cycle running
  logic                                 phase;       // 0 low byte, 1 high byte
  logic [boot_pkg::flash_wait_bits-1:0] wait_cnt;    // Cycles on current address
  logic [7:0]                           low_byte;    // First byte of the pair
  logic                                 start;
  logic                                 byte_ready;  // Sample point of a byte

  assign start      = fetch && !reading;                          // Copier never overlaps
  assign byte_ready = reading && (wait_cnt == boot_pkg::flash_wait_last);

  // ----------------------------
  // Read sequencing
  // ----------------------------
  always_ff @(posedge clock_24) begin
    if (reset) begin
      reading    <= 1'b0;
      phase      <= 1'b0;
      wait_cnt   <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;                                         // Pulse by default
      if (start) begin
        reading  <= 1'b1;
        phase    <= 1'b0;
        wait_cnt <= '0;
      end else if (reading && !byte_ready) begin
        wait_cnt <= wait_cnt + 1'b1;                              // Hold address
      end else if (byte_ready && !phase) begin
        phase    <= 1'b1;                                         // Move to high byte
        wait_cnt <= '0;
      end else if (byte_ready) begin
        reading    <= 1'b0;                                       // Both bytes in
        word_valid <= 1'b1;
      end
    end
  end

  // ----------------------------
  // Address and data path
  // ----------------------------
  always_ff @(posedge clock_24) begin
    if (start) begin
      fl_addr <= {word_index, 1'b0};                              // Low byte first
    end else if (byte_ready && !phase) begin
      low_byte   <= fl_dq;
      fl_addr[0] <= 1'b1;                                         // Odd byte next
    end else if (byte_ready) begin
      word_data <= {fl_dq, low_byte};
    end
  end

  assign fl_ce_n  = !reading;   // Selected only during a read
  assign fl_oe_n  = !reading;
  assign fl_we_n  = 1'b1;       // Read only
  assign fl_rst_n = !reset;     // Flash held in reset with the copier

endmodule

// ==== hdl/boot_copier.sv ====
// ----------------------------
// Copy sequencer between flash reader and SRAM writer
// Counts words from the strap and keeps a running 16-bit checksum
// ----------------------------
`timescale 1ns/1ps

module boot_copier (
  input  logic                                  clock_24,
  input  logic                                  reset,
  input  logic [3:0]                            strap,         // Blocks minus one
  input  logic                                  word_valid,
  input  logic [boot_pkg::word_width-1:0]       word_data,
  input  logic                                  busy,          // Writer occupied
  output logic                                  fetch,
  output logic [boot_pkg::word_index_width-1:0] word_index,
  output logic                                  write,
  output logic [boot_pkg::sram_addr_width-1:0]  write_addr,
  output logic [boot_pkg::word_width-1:0]       write_data,
  output logic [boot_pkg::word_width-1:0]       checksum,
  output logic [boot_pkg::sram_addr_width-1:0]  words_copied,
  output logic                                  done
);

  boot_pkg::copier_state_t                     state;
  logic [boot_pkg::sram_addr_width-1:0]        total_words;   // Words to copy
  logic [boot_pkg::sram_addr_width-1:0]        strap_blocks;
  logic [boot_pkg::word_index_width-1:0]       index_total;
  logic [boot_pkg::word_width-1:0]             word_buf;      // One word held
  logic                                        more_words;
  logic                                        last_store;
  logic                                        store_go;

  assign strap_blocks = {{(boot_pkg::sram_addr_width - 4){1'b0}}, strap} + 1'b1;
  assign index_total  = {{(boot_pkg::word_index_width - boot_pkg::sram_addr_width){1'b0}},
                         total_words};
  assign more_words   = (word_index + 1'b1) < index_total;        // Another read due
  assign last_store   = (words_copied + 1'b1) == total_words;
  assign store_go     = (state == boot_pkg::st_store) && !busy;   // Writer free

  // ----------------------------
  // Control FSM
  // ----------------------------
  always_ff @(posedge clock_24) begin
    if (reset) begin
      state        <= boot_pkg::st_idle;
      fetch        <= 1'b0;
      write        <= 1'b0;
      done         <= 1'b0;
      word_index   <= '0;
      words_copied <= '0;
      checksum     <= '0;
      total_words  <= '0;
    end else begin
      fetch <= 1'b0;                                              // Pulses
      write <= 1'b0;
      case (state)
        boot_pkg::st_idle: begin
          total_words <= strap_blocks * boot_pkg::block_words;
          word_index  <= '0;
          state       <= boot_pkg::st_fetch;
        end
        boot_pkg::st_fetch: begin
          fetch <= 1'b1;                                          // Word zero
          state <= boot_pkg::st_wait_word;
        end
        boot_pkg::st_wait_word: begin
          if (word_valid) begin
            if (more_words) begin
              fetch      <= 1'b1;                                 // Overlap next read
              word_index <= word_index + 1'b1;
            end
            state <= boot_pkg::st_store;
          end
        end
        boot_pkg::st_store: begin
          if (store_go) begin
            write        <= 1'b1;
            checksum     <= checksum + word_buf;                  // Sum at issue
            words_copied <= words_copied + 1'b1;
            state        <= last_store ? boot_pkg::st_done : boot_pkg::st_wait_word;
          end
        end
        boot_pkg::st_done: begin
          if (!write && !busy) done <= 1'b1;                      // Last write drained
        end
        default: state <= boot_pkg::st_idle;
      endcase
    end
  end

  // Word buffer and write payload
  always_ff @(posedge clock_24) begin
    if ((state == boot_pkg::st_wait_word) && word_valid) word_buf <= word_data;
    if (store_go) begin
      write_addr <= words_copied;                                 // Next SRAM word
      write_data <= word_buf;
    end
  end

endmodule

// ==== hdl/sram_writer.sv ====
// ----------------------------
// SRAM write side of the copier
// One write pulse gives one timed strobe on the asynchronous SRAM
// ----------------------------
`timescale 1ns/1ps

module sram_writer (
  input  logic                                 clock_24,
  input  logic                                 reset,
  input  logic                                 write,       // One cycle request
  input  logic [boot_pkg::sram_addr_width-1:0] write_addr,
  input  logic [boot_pkg::word_width-1:0]      write_data,
  output logic                                 busy,
  output logic [boot_pkg::sram_addr_width-1:0] sram_addr,
  output logic [boot_pkg::word_width-1:0]      sram_dq,     // Driven only, never read
  output logic                                 sram_we_n,
  output logic                                 sram_ce_n,
  output logic                                 sram_oe_n,
  output logic                                 sram_ub_n,
  output logic                                 sram_lb_n
);

  logic                                we_low;   // Strobe asserted
  logic [boot_pkg::write_cnt_bits-1:0] we_cnt;   // Low cycles so far
  logic                                active;   // Strobe plus hold cycle

  // Strobe timing
  always_ff @(posedge clock_24) begin
    if (reset) begin
      we_low <= 1'b0;
      we_cnt <= '0;
      active <= 1'b0;
    end else if (write) begin
      we_low <= 1'b1;                                        // Low from next cycle
      we_cnt <= '0;
      active <= 1'b1;
    end else if (we_low) begin
      if (we_cnt == boot_pkg::write_cnt_last) we_low <= 1'b0;
      else we_cnt <= we_cnt + 1'b1;
    end else if (active) begin
      active <= 1'b0;                                        // Data held past rising edge
    end
  end

  // Address and data latch
  always_ff @(posedge clock_24) begin
    if (write) begin
      sram_addr <= write_addr;
      sram_dq   <= write_data;
    end
  end

  assign busy      = active;
  assign sram_we_n = !we_low;
  assign sram_ce_n = !active;   // Chip selected across the whole write
  assign sram_ub_n = !active;   // Full word
  assign sram_lb_n = !active;
  assign sram_oe_n = 1'b1;      // No reads

endmodule

// ==== hdl/status_display.sv ====
// ----------------------------
// Board status for the copier
// Checksum on the hex digits, done and word count on the LEDs
// ----------------------------
`timescale 1ns/1ps

module status_display (
  input  logic                                 clock_24,
  input  logic                                 reset,
  input  logic [boot_pkg::word_width-1:0]      checksum,
  input  logic [boot_pkg::sram_addr_width-1:0] words_copied,
  input  logic                                 done,
  output logic [6:0]                           hex0,          // Lowest nibble
  output logic [6:0]                           hex1,
  output logic [6:0]                           hex2,
  output logic [6:0]                           hex3,          // Highest nibble
  output logic [7:0]                           ledg,
  output logic [9:0]                           ledr
);

  // ----------------------------
  // Seven segment digits
  // ----------------------------
  always_ff @(posedge clock_24) begin
    if (reset) begin
      hex0 <= 7'h7f;                                          // All segments off
      hex1 <= 7'h7f;
      hex2 <= 7'h7f;
      hex3 <= 7'h7f;
    end else begin
      hex0 <= boot_pkg::seg_encode(checksum[3:0]);
      hex1 <= boot_pkg::seg_encode(checksum[7:4]);
      hex2 <= boot_pkg::seg_encode(checksum[11:8]);
      hex3 <= boot_pkg::seg_encode(checksum[15:12]);
    end
  end

  // ----------------------------
  // LEDs
  // ----------------------------
  always_ff @(posedge clock_24) begin
    if (reset) begin
      ledg <= '0;
      ledr <= '0;
    end else begin
      ledg <= {7'b0000000, done};                             // Green 0 is done
      ledr <= words_copied[9:0];                              // Progress count
    end
  end

endmodule

// ==== hdl/boot_top.sv ====
// ----------------------------
// Board level top of the boot copier
// Flash and SRAM pins, switches, hex digits and LEDs
// ----------------------------
`timescale 1ns/1ps

module boot_top (
  input  logic                                 clock_24,
  input  logic                                 reset,
  input  logic [9:0]                           sw,          // Low four are the strap
  output logic [boot_pkg::flash_addr_width-1:0] fl_addr,
  input  logic [7:0]                           fl_dq,
  output logic                                 fl_ce_n,
  output logic                                 fl_oe_n,
  output logic                                 fl_we_n,
  output logic                                 fl_rst_n,
  output logic [boot_pkg::sram_addr_width-1:0] sram_addr,
  output logic [boot_pkg::word_width-1:0]      sram_dq,
  output logic                                 sram_we_n,
  output logic                                 sram_ce_n,
  output logic                                 sram_oe_n,
  output logic                                 sram_ub_n,
  output logic                                 sram_lb_n,
  output logic [6:0]                           hex0,
  output logic [6:0]                           hex1,
  output logic [6:0]                           hex2,
  output logic [6:0]                           hex3,
  output logic [7:0]                           ledg,
  output logic [9:0]                           ledr
);

  logic                                  fetch;         // Reader request
  logic [boot_pkg::word_index_width-1:0] word_index;
  logic [boot_pkg::word_width-1:0]       word_data;
  logic                                  word_valid;
  logic                                  write;         // Writer request
  logic [boot_pkg::sram_addr_width-1:0]  write_addr;
  logic [boot_pkg::word_width-1:0]       write_data;
  logic                                  busy;
  logic [boot_pkg::word_width-1:0]       checksum;
  logic [boot_pkg::sram_addr_width-1:0]  words_copied;
  logic                                  done;

  flash_reader flash_reader_inst (
    .clock_24, .reset, .fetch, .word_index, .fl_addr, .fl_dq,
    .fl_ce_n, .fl_oe_n, .fl_we_n, .fl_rst_n, .word_data, .word_valid
  );

  boot_copier boot_copier_inst (
    .clock_24, .reset, .strap(sw[3:0]), .word_valid, .word_data, .busy,
    .fetch, .word_index, .write, .write_addr, .write_data,
    .checksum, .words_copied, .done
  );

  sram_writer sram_writer_inst (
    .clock_24, .reset, .write, .write_addr, .write_data, .busy,
    .sram_addr, .sram_dq, .sram_we_n, .sram_ce_n, .sram_oe_n, .sram_ub_n, .sram_lb_n
  );

  status_display status_display_inst (
    .clock_24, .reset, .checksum, .words_copied, .done,
    .hex0, .hex1, .hex2, .hex3, .ledg, .ledr
  );

endmodule

// ==== bench/mem_models.sv ====
// ------------------------------
// Behavioral memories around the boot copier
// Flash ROM with a computed byte pattern, SRAM that records each write
// ------------------------------
`timescale 1ns/1ps

module flash_rom (
  input  logic [boot_pkg::flash_addr_width-1:0] addr,
  input  logic                                  ce_n,
  input  logic                                  oe_n,
  output logic [7:0]                            dq
);

  // Byte at a is the low 8 bits of a * 37 + 11 while selected
  assign dq = (!ce_n && !oe_n) ? 8'(addr * 22'd37 + 22'd11) : 'x;

endmodule

module sram_capture (
  input  logic                                 clear,           // Follows DUT reset
  input  logic [boot_pkg::sram_addr_width-1:0] expected_count,
  input  logic [boot_pkg::sram_addr_width-1:0] sram_addr,
  input  logic [boot_pkg::word_width-1:0]      sram_dq,
  input  logic                                 sram_we_n,
  input  logic                                 sram_ce_n
);

  logic [boot_pkg::word_width-1:0]      mem [0:255];            // Largest image is 256 words
  logic                                 written [0:255];
  int                                   store_count;
  logic                                 overflow;               // Store past the image
  logic [boot_pkg::sram_addr_width-1:0] first_addr;             // Where the copy began

  // Store on the rising strobe edge while selected
  always @(posedge sram_we_n or posedge clear) begin
    if (clear) begin
      store_count <= 0;
      overflow    <= 1'b0;
      first_addr  <= '0;
      for (int i = 0; i < 256; i++) written[i] <= 1'b0;
    end else if (!sram_ce_n) begin
      if (store_count == 0) first_addr <= sram_addr;
      if (sram_addr >= expected_count || sram_addr > 18'd255) begin
        overflow <= 1'b1;
      end else begin
        mem[sram_addr[7:0]]     <= sram_dq;
        written[sram_addr[7:0]] <= 1'b1;
      end
      store_count <= store_count + 1;
    end
  end

endmodule

// ==== bench/tb_boot.sv ====
// ------------------------------
// Testbench for the boot copier top level
// Runs fixed, random and interrupted copies and checks SRAM and display
// ------------------------------
`timescale 1ns/1ps

module tb_boot;

  localparam int watchdog_cycles = 20 * 256 * 12 * 6;  // Six copies at worst case

  logic        clock_24;
  logic        reset;
  logic [9:0]  sw;
  logic [21:0] fl_addr;
  logic [7:0]  fl_dq;
  logic        fl_ce_n, fl_oe_n, fl_we_n, fl_rst_n;
  logic [17:0] sram_addr;
  logic [15:0] sram_dq;
  logic        sram_we_n, sram_ce_n, sram_oe_n, sram_ub_n, sram_lb_n;
  logic [6:0]  hex0, hex1, hex2, hex3;
  logic [7:0]  ledg;
  logic [9:0]  ledr;
  logic [17:0] expected_count;
  int          error_count  = 0;
  int          runs_started = 0;
  int          runs_checked = 0;

  boot_top boot_top_inst (.*);
  flash_rom flash_rom_inst (.addr(fl_addr), .ce_n(fl_ce_n), .oe_n(fl_oe_n), .dq(fl_dq));
  sram_capture sram_capture_inst (.clear(reset), .expected_count, .sram_addr, .sram_dq,
                                  .sram_we_n, .sram_ce_n);

  initial begin
    clock_24 = 1'b0;
    forever #10 clock_24 = ~clock_24;                   // 20 ns period
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [7:0] flash_byte(input int a);
    return 8'(a * 37 + 11);
  endfunction

  function automatic logic [15:0] expected_word(input int n);
    return {flash_byte(2 * n + 1), flash_byte(2 * n)};  // Low byte first in flash
  endfunction

  function automatic logic [15:0] expected_sum(input int count);
    logic [15:0] sum;
    sum = '0;
    for (int n = 0; n < count; n++) sum = sum + expected_word(n);
    return sum;
  endfunction

  task automatic report_mismatch(input string what);
    error_count++;
    $display("FAIL %0t: %s", $time, what);
  endtask

  // Reset with a strap and confirm blanked outputs
  task automatic apply_reset(input logic [3:0] strap);
    @(posedge clock_24);
    #2;
    reset          = 1'b1;
    sw             = {6'b000000, strap};
    expected_count = 18'((int'(strap) + 1) * 16);
    repeat (16) @(posedge clock_24);
    #2;
    if (ledg !== 8'h00 || ledr !== 10'h000) report_mismatch("LEDs not cleared in reset");
    if (hex0 !== 7'h7f || hex1 !== 7'h7f || hex2 !== 7'h7f || hex3 !== 7'h7f)
      report_mismatch("hex digits not blank in reset");
    if (fl_ce_n !== 1'b1 || fl_oe_n !== 1'b1 || sram_we_n !== 1'b1 || sram_ce_n !== 1'b1)
      report_mismatch("memory strobes active in reset");
    reset = 1'b0;
  endtask

  task automatic run_copy(input logic [3:0] strap);
    apply_reset(strap);
    runs_started++;
    wait (runs_checked == runs_started);                // Checker finished this run
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    reset          = 1'b1;
    sw             = '0;
    expected_count = '0;
    void'($urandom(32'h0b864839));
    run_copy(4'd0);                                     // Single block
    repeat (3) run_copy(4'($urandom & 32'hf));
    apply_reset(4'd15);                                 // Long copy to interrupt
    wait (sram_capture_inst.store_count >= 40);
    run_copy(4'($urandom & 32'hf));                     // Reset mid copy and restart
    $display("Runs checked %0d, errors %0d", runs_checked, error_count);
    if (error_count == 0) $display("Result: PASSED");
    else $display("Result: FAILED");
    $finish;
  end

  // ------------------------------
  // Comparing process
  // ------------------------------
  initial begin
    int          count;
    int          stores_at_done;
    logic [15:0] sum;
    forever begin
      wait (runs_started > runs_checked);
      count = (int'(sw[3:0]) + 1) * 16;
      sum   = expected_sum(count);
      while (ledg[0] !== 1'b1) begin
        @(negedge clock_24);                            // Stable sample point
        if (ledg[0] === 1'b1 && sram_capture_inst.store_count < count)
          report_mismatch("done set before the last store");
      end
      if (sram_capture_inst.store_count != count)
        report_mismatch($sformatf("store count %0d expected %0d",
                                  sram_capture_inst.store_count, count));
      if (sram_capture_inst.overflow) report_mismatch("store past last image word");
      if (sram_capture_inst.first_addr !== 18'd0) report_mismatch("copy did not start at 0");
      for (int n = 0; n < count; n++) begin
        if (!sram_capture_inst.written[n] || sram_capture_inst.mem[n] !== expected_word(n))
          report_mismatch($sformatf("word %0d got %h expected %h", n,
                                    sram_capture_inst.mem[n], expected_word(n)));
      end
      if (hex0 !== boot_pkg::seg_encode(sum[3:0]) || hex1 !== boot_pkg::seg_encode(sum[7:4]) ||
          hex2 !== boot_pkg::seg_encode(sum[11:8]) || hex3 !== boot_pkg::seg_encode(sum[15:12]))
        report_mismatch($sformatf("hex digits do not show checksum %h", sum));
      if (ledr !== 10'(count)) report_mismatch($sformatf("ledr %h expected %h", ledr, count));
      stores_at_done = sram_capture_inst.store_count;
      repeat (40) begin
        @(negedge clock_24);
        if (fl_oe_n !== 1'b1 || fl_ce_n !== 1'b1) report_mismatch("flash read after done");
        if (ledg[0] !== 1'b1) report_mismatch("done dropped");
      end
      if (sram_capture_inst.store_count != stores_at_done) report_mismatch("store after done");
      runs_checked++;
    end
  end

  // ------------------------------
  // Pin rules every cycle
  // ------------------------------
  initial begin
    @(posedge clock_24);
    forever begin
      @(negedge clock_24);
      if (fl_we_n !== 1'b1) report_mismatch("flash write enable asserted");
      if (fl_rst_n !== !reset) report_mismatch("flash reset does not follow reset");
      if (sram_oe_n !== 1'b1) report_mismatch("SRAM output enable asserted");
      if (sram_we_n === 1'b0 &&
          (sram_ce_n !== 1'b0 || sram_ub_n !== 1'b0 || sram_lb_n !== 1'b0))
        report_mismatch("SRAM write strobe without chip and byte enables");
    end
  end

  // Watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clock_24);
    $display("Timeout: the copies did not finish within %0d cycles", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/boot_pkg.sv
hdl/flash_reader.sv
hdl/boot_copier.sv
hdl/sram_writer.sv
hdl/status_display.sv
hdl/boot_top.sv
bench/mem_models.sv
bench/tb_boot.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the boot copier testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_boot -f filelist.f -o tb_boot_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_boot_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit 0
